//--- src/dac_pkg.sv
// DAC sawtooth package with shared constants and the converter command frame

`default_nettype none

package dac_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Converter and timing constants
   ////////////////////////////////////////////////////////////////////////////

   // Converter resolution and SPI frame size
   localparam int CODE_W = 12;
   localparam int FRAME_W = 16;

   // Sample period in pll_clk cycles
   // One frame costs 2 x FRAME_W x SCLK_HALF_CYCLES + CSN_IDLE_CYCLES
   // = 2 x 16 x 5 + 2 = 162 cycles, which fits inside 200
   localparam int TICK_CYCLES = 200;

   // SCLK half-period, 5 cycles gives 10 MHz at 100 MHz pll_clk
   localparam int SCLK_HALF_CYCLES = 5;

   // Chip select high time between frames
   localparam int CSN_IDLE_CYCLES = 2;

   // Frame slots in the SPI transmitter
   localparam int TX_CREDITS = 1;

   // Credit counter keeps one spare value so an extra return shows up
   localparam int CREDIT_W = $clog2(TX_CREDITS + 2);

   ////////////////////////////////////////////////////////////////////////////
   // Command frame, MSB first on the wire
   ////////////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic              ab;      // Channel select, 0 is channel A
      logic              buf_en;  // Input buffer, kept off
      logic              gain_n;  // 1 selects 1x gain
      logic              shdn_n;  // 1 keeps the output active
      logic [CODE_W-1:0] code;    // Output code
   } dac_cmd_t;

endpackage

`default_nettype wire

//--- src/tick_divider.sv
// Tick divider giving a one-cycle pulse every MAX clock cycles

`timescale 1ns/100ps
`default_nettype none

module tick_divider #(
   parameter int MAX = 200
) (
   input  logic pll_clk,
   input  logic srst,
   output logic tick
);

   // Counter wide enough for MAX-1, never below one bit
   localparam int CNT_W = (MAX > 1) ? $clog2(MAX) : 1;

   logic [CNT_W-1:0] cnt;

   ////////////////////////////////////////////////////////////////////////////
   // Down-counter with reload
   ////////////////////////////////////////////////////////////////////////////

   // Reset loads a full period so the first tick lands MAX cycles
   // after reset is released
   // Tick is registered, so it comes one cycle after the zero count
   always_ff @(posedge pll_clk) begin
      if (srst) begin
         cnt  <= CNT_W'(MAX - 1);
         tick <= 1'b0;
      end else if (cnt == '0) begin
         // End of period, reload and fire
         cnt  <= CNT_W'(MAX - 1);
         tick <= 1'b1;
      end else begin
         cnt  <= cnt - 1'b1;
         tick <= 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- src/ramp_counter.sv
// Ramp counter holding the sawtooth phase, one step per sample tick

`timescale 1ns/100ps
`default_nettype none

module ramp_counter (
   input  logic                       pll_clk,
   input  logic                       srst,
   input  logic                       tick,
   output logic [dac_pkg::CODE_W-1:0] code
);

   ////////////////////////////////////////////////////////////////////////////
   // Sawtooth phase
   ////////////////////////////////////////////////////////////////////////////

   // Phase advances on every tick whether a frame went out or not
   // A dropped sample therefore shows up as a skipped code on the DAC
   // Full scale rolls over to zero by plain binary wrap

   // The control block samples code on the tick cycle itself, so the
   // value seen by the first frame is still the reset value 0
   always_ff @(posedge pll_clk) begin
      if (srst) begin
         code <= '0;
      end else if (tick) begin
         code <= code + 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- src/spi_tx.sv
// SPI master sending one 16-bit DAC command per request and returning a credit

`timescale 1ns/100ps
`default_nettype none

module spi_tx #(
   parameter int HALF_CYCLES = 5
) (
   input  logic              pll_clk,
   input  logic              srst,
   input  logic              tx_valid,
   input  dac_pkg::dac_cmd_t tx_cmd,
   output logic              tx_credit,
   output logic              csn,
   output logic              sclk,
   output logic              sdi
);

   localparam int FRAME_W = dac_pkg::FRAME_W;
   localparam int IDLE_CYCLES = dac_pkg::CSN_IDLE_CYCLES;

   // One counter times both SCLK half-periods and the chip select gap
   localparam int CNT_MAX = (HALF_CYCLES > IDLE_CYCLES) ? HALF_CYCLES : IDLE_CYCLES;
   localparam int CNT_W = $clog2(CNT_MAX + 1);
   localparam int BIT_W = $clog2(FRAME_W);

   typedef enum logic [1:0] {
      IDLE,
      LEAD,
      SHIFT,
      GAP
   } state_t;

   state_t             state;
   logic [CNT_W-1:0]   half_cnt;
   logic [BIT_W-1:0]   bit_cnt;
   logic [FRAME_W-1:0] shreg;
   logic               half_end;
   logic               gap_end;
   logic               last_bit;

   assign half_end = (half_cnt == CNT_W'(HALF_CYCLES - 1));
   assign gap_end  = (half_cnt == CNT_W'(IDLE_CYCLES - 1));
   assign last_bit = (bit_cnt == BIT_W'(FRAME_W - 1));

   // Slot is freed on the last cycle of the chip select gap
   assign tx_credit = (state == GAP) && gap_end;

   ////////////////////////////////////////////////////////////////////////////
   // Frame FSM
   ////////////////////////////////////////////////////////////////////////////

   // IDLE  : csn high, waiting for a command
   // LEAD  : csn low, first bit on sdi, sclk low for one half-period
   // SHIFT : sclk toggles, sdi moves after each falling edge
   // GAP   : csn high again for the minimum idle time
   always_ff @(posedge pll_clk) begin
      if (srst) begin
         state    <= IDLE;
         half_cnt <= '0;
         bit_cnt  <= '0;
         csn      <= 1'b1;
         sclk     <= 1'b0;
         sdi      <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (tx_valid) begin
                  // Take the command and present its MSB at once
                  state    <= LEAD;
                  half_cnt <= '0;
                  bit_cnt  <= '0;
                  csn      <= 1'b0;
                  sdi      <= tx_cmd[FRAME_W-1];
               end
            end
            LEAD: begin
               half_cnt <= half_end ? '0 : half_cnt + 1'b1;
               if (half_end) begin
                  // First rising edge, MSB is sampled here
                  sclk  <= 1'b1;
                  state <= SHIFT;
               end
            end
            SHIFT: begin
               half_cnt <= half_end ? '0 : half_cnt + 1'b1;
               if (half_end && !sclk) begin
                  sclk <= 1'b1;
               end else if (half_end && last_bit) begin
                  // Last falling edge closes the frame
                  sclk     <= 1'b0;
                  sdi      <= 1'b0;
                  csn      <= 1'b1;
                  state    <= GAP;
               end else if (half_end) begin
                  // Falling edge, next bit goes out while sclk is low
                  sclk    <= 1'b0;
                  sdi     <= shreg[FRAME_W-2];
                  bit_cnt <= bit_cnt + 1'b1;
               end
            end
            GAP: begin
               half_cnt <= half_cnt + 1'b1;
               if (gap_end) begin
                  state <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // Shift register, loaded on request and moved on every falling edge
   always_ff @(posedge pll_clk) begin
      if (state == IDLE && tx_valid) begin
         shreg <= tx_cmd;
      end else if (state == SHIFT && half_end && sclk) begin
         shreg <= shreg << 1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////////////////////

   // Single slot, the sender must hold off until the credit comes back
   a_single_slot: assert property (
      @(posedge pll_clk) disable iff (srst)
      tx_valid |-> (state == IDLE)
   ) else $error("spi_tx: command arrived while a frame was in progress");

endmodule

`default_nettype wire

//--- src/dac_ctrl.sv
// DAC control block, qualifies reset, holds the frame credit and issues commands

`timescale 1ns/100ps
`default_nettype none

module dac_ctrl (
   input  logic                       pll_clk,
   input  logic                       rst,
   input  logic                       pll_locked,
   input  logic                       tick,
   input  logic [dac_pkg::CODE_W-1:0] code,
   input  logic                       gain_n,
   input  logic                       shdn_n,
   input  logic                       tx_credit,
   output logic                       srst,
   output logic                       tx_valid,
   output dac_pkg::dac_cmd_t          tx_cmd,
   output logic                       busy,
   output logic                       overrun
);

   localparam int CREDIT_W = dac_pkg::CREDIT_W;
   localparam logic [CREDIT_W-1:0] CREDIT_FULL = CREDIT_W'(dac_pkg::TX_CREDITS);

   logic [CREDIT_W-1:0] credit_cnt;
   logic                issue;

   ////////////////////////////////////////////////////////////////////////////
   // Reset qualification
   ////////////////////////////////////////////////////////////////////////////

   // Held in reset while the button is pressed or the PLL is unlocked
   // Registered once so the whole datapath sees one clean edge
   always_ff @(posedge pll_clk) begin
      srst <= rst | ~pll_locked;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Credit and frame issue
   ////////////////////////////////////////////////////////////////////////////

   // A tick only turns into a frame when a slot is free
   assign issue = tick && (credit_cnt != '0);

   always_ff @(posedge pll_clk) begin
      if (srst) begin
         credit_cnt <= CREDIT_FULL;
         tx_valid   <= 1'b0;
         overrun    <= 1'b0;
      end else begin
         // One taken per issue, one given back per credit pulse
         credit_cnt <= credit_cnt + CREDIT_W'(tx_credit) - CREDIT_W'(issue);
         tx_valid   <= issue;
         // Sample lost, sticky until the next reset
         if (tick && credit_cnt == '0) begin
            overrun <= 1'b1;
         end
      end
   end

   // Command payload, switch levels taken on the tick cycle
   always_ff @(posedge pll_clk) begin
      if (issue) begin
         tx_cmd.ab     <= 1'b0;
         tx_cmd.buf_en <= 1'b0;
         tx_cmd.gain_n <= gain_n;
         tx_cmd.shdn_n <= shdn_n;
         tx_cmd.code   <= code;
      end
   end

   // Busy while any slot is out with the transmitter
   assign busy = (credit_cnt != CREDIT_FULL);

   ////////////////////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////////////////////

   // Transmitter never returns more slots than it has
   a_credit_max: assert property (
      @(posedge pll_clk) disable iff (srst)
      credit_cnt <= CREDIT_FULL
   ) else $error("dac_ctrl: credit count above transmitter slots");

endmodule

`default_nettype wire

//--- src/dac_sawtooth.sv
// Sawtooth generator top, ramp samples sent to an MCP4821-style SPI DAC

`timescale 1ns/100ps
`default_nettype none

module dac_sawtooth (
   input  logic pll_clk,
   input  logic rst,
   input  logic pll_locked,
   input  logic gain_n,
   input  logic shdn_n,
   output logic dac_csn,
   output logic dac_sclk,
   output logic dac_sdi,
   output logic led,
   output logic overrun
);

   logic                       srst;
   logic                       tick;
   logic [dac_pkg::CODE_W-1:0] code;
   logic                       tx_valid;
   dac_pkg::dac_cmd_t          tx_cmd;
   logic                       tx_credit;

   ////////////////////////////////////////////////////////////////////////////
   // Control and reset
   ////////////////////////////////////////////////////////////////////////////

   // LED shows a frame in flight
   dac_ctrl u_dac_ctrl (
      .pll_clk    (pll_clk),
      .rst        (rst),
      .pll_locked (pll_locked),
      .tick       (tick),
      .code       (code),
      .gain_n     (gain_n),
      .shdn_n     (shdn_n),
      .tx_credit  (tx_credit),
      .srst       (srst),
      .tx_valid   (tx_valid),
      .tx_cmd     (tx_cmd),
      .busy       (led),
      .overrun    (overrun)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Datapath
   ////////////////////////////////////////////////////////////////////////////

   // Sample rate
   tick_divider #(
      .MAX (dac_pkg::TICK_CYCLES)
   ) u_tick_divider (
      .pll_clk (pll_clk),
      .srst    (srst),
      .tick    (tick)
   );

   ramp_counter u_ramp_counter (
      .pll_clk (pll_clk),
      .srst    (srst),
      .tick    (tick),
      .code    (code)
   );

   // SPI speed, independent of the sample rate
   spi_tx #(
      .HALF_CYCLES (dac_pkg::SCLK_HALF_CYCLES)
   ) u_spi_tx (
      .pll_clk   (pll_clk),
      .srst      (srst),
      .tx_valid  (tx_valid),
      .tx_cmd    (tx_cmd),
      .tx_credit (tx_credit),
      .csn       (dac_csn),
      .sclk      (dac_sclk),
      .sdi       (dac_sdi)
   );

endmodule

`default_nettype wire

//--- dv/dac_frame_checker.sv
// Frame checker decoding SPI frames at the DAC pins and comparing them with expected commands

`timescale 1ns/100ps
`default_nettype none

module dac_frame_checker (
   input  logic pll_clk,
   input  logic rst,
   input  logic pll_locked,
   input  logic gain_n,
   input  logic shdn_n,
   input  logic dac_csn,
   input  logic dac_sclk,
   input  logic dac_sdi,
   input  logic led,
   input  logic overrun,
   output int   frame_count,
   output int   error_count
);

   localparam int FRAME_W = dac_pkg::FRAME_W;
   localparam int CODE_W = dac_pkg::CODE_W;

   logic               armed;
   logic               in_frame;
   logic               prev_csn;
   logic               prev_sclk;
   logic [FRAME_W-1:0] frame_bits;
   int                 sclk_edges;
   logic [CODE_W-1:0]  exp_code;
   logic               frame_gain_n;
   logic               frame_shdn_n;
   logic               led_reported;
   logic               overrun_reported;

   initial begin
      frame_count      = 0;
      error_count      = 0;
      armed            = 1'b0;
      in_frame         = 1'b0;
      prev_csn         = 1'b1;
      prev_sclk        = 1'b0;
      frame_bits       = '0;
      sclk_edges       = 0;
      exp_code         = '0;
      frame_gain_n     = 1'b0;
      frame_shdn_n     = 1'b0;
      led_reported     = 1'b0;
      overrun_reported = 1'b0;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////////////////////

   // Channel A, buffer off, switch levels, then the ramp code
   function automatic logic [FRAME_W-1:0] expected_frame(input logic [CODE_W-1:0] code,
                                                         input logic g, input logic s);
      dac_pkg::dac_cmd_t cmd;
      cmd.ab     = 1'b0;
      cmd.buf_en = 1'b0;
      cmd.gain_n = g;
      cmd.shdn_n = s;
      cmd.code   = code;
      return cmd;
   endfunction

   task automatic close_frame();
      logic [FRAME_W-1:0] exp_bits;
      exp_bits    = expected_frame(exp_code, frame_gain_n, frame_shdn_n);
      frame_count = frame_count + 1;
      if (sclk_edges != FRAME_W) begin
         error_count++;
         $display("Fail sclk_count frame %0d: expected %0d, actual %0d",
                  frame_count, FRAME_W, sclk_edges);
      end
      if (frame_bits !== exp_bits) begin
         error_count++;
         $display("Fail frame_word frame %0d: expected %h, actual %h",
                  frame_count, exp_bits, frame_bits);
      end
      // Sawtooth wraps at full scale
      exp_code = exp_code + 1'b1;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Pin monitor
   ////////////////////////////////////////////////////////////////////////////

   // Pins are read before the clock edge updates them, edges found from history
   always @(posedge pll_clk) begin
      if (rst || !pll_locked) begin
         // Ramp restarts at 0 after any reset
         armed     = 1'b1;
         in_frame  = 1'b0;
         exp_code  = '0;
         prev_csn  = 1'b1;
         prev_sclk = 1'b0;
      end else if (armed) begin
         if (overrun !== 1'b0 && !overrun_reported) begin
            error_count++;
            overrun_reported = 1'b1;
            $display("Fail overrun_low: expected 0, actual %b", overrun);
         end
         if (dac_csn === 1'b0 && led !== 1'b1 && !led_reported) begin
            error_count++;
            led_reported = 1'b1;
            $display("Fail led_busy frame %0d: expected 1, actual %b", frame_count + 1, led);
         end
         // Start of frame, switch levels latched here
         if (prev_csn === 1'b1 && dac_csn === 1'b0) begin
            in_frame     = 1'b1;
            frame_bits   = '0;
            sclk_edges   = 0;
            frame_gain_n = gain_n;
            frame_shdn_n = shdn_n;
            led_reported = 1'b0;
         end
         // Bit valid at rising sclk
         if (in_frame && dac_csn === 1'b0 && prev_sclk === 1'b0 && dac_sclk === 1'b1) begin
            frame_bits = {frame_bits[FRAME_W-2:0], dac_sdi};
            sclk_edges++;
         end
         if (in_frame && prev_csn === 1'b0 && dac_csn === 1'b1) begin
            in_frame = 1'b0;
            close_frame();
         end
         prev_csn  = dac_csn;
         prev_sclk = dac_sclk;
      end
   end

endmodule

`default_nettype wire

//--- dv/tb_dac_sawtooth.sv
// Testbench top for the sawtooth DAC driver with clock, reset, switch stimulus and watchdog

`timescale 1ns/100ps
`default_nettype none

module tb_dac_sawtooth;

   localparam int CLK_HALF_NS = 10;
   localparam int TICK_CYCLES = dac_pkg::TICK_CYCLES;
   localparam int FRAMES_PER_PHASE = 20;
   // Cycles after csn rises before the switches move, well before the next tick
   localparam int SWITCH_DELAY = 10;
   // Cycles after csn falls before the PLL drops, sclk is high by then
   localparam int LOCK_LOSS_DELAY = 7;
   // Two runs of 45 sample periods each, in ns
   localparam int WATCHDOG_NS = 2 * 45 * TICK_CYCLES * 2 * CLK_HALF_NS;

   logic        pll_clk;
   logic        rst;
   logic        pll_locked;
   logic        gain_n;
   logic        shdn_n;
   logic        dac_csn;
   logic        dac_sclk;
   logic        dac_sdi;
   logic        led;
   logic        overrun;
   int          frame_count;
   int          checker_errors;
   int          tb_errors;
   int          active_cycles = 0;
   int          cycles_mark;
   int          periods;
   int          frame_diff;
   logic [31:0] lcg_state;

   ////////////////////////////////////////////////////////////////////////////
   // DUT and checker
   ////////////////////////////////////////////////////////////////////////////

   dac_sawtooth u_dac_sawtooth (
      .pll_clk    (pll_clk),
      .rst        (rst),
      .pll_locked (pll_locked),
      .gain_n     (gain_n),
      .shdn_n     (shdn_n),
      .dac_csn    (dac_csn),
      .dac_sclk   (dac_sclk),
      .dac_sdi    (dac_sdi),
      .led        (led),
      .overrun    (overrun)
   );

   dac_frame_checker u_frame_checker (
      .pll_clk     (pll_clk),
      .rst         (rst),
      .pll_locked  (pll_locked),
      .gain_n      (gain_n),
      .shdn_n      (shdn_n),
      .dac_csn     (dac_csn),
      .dac_sclk    (dac_sclk),
      .dac_sdi     (dac_sdi),
      .led         (led),
      .overrun     (overrun),
      .frame_count (frame_count),
      .error_count (checker_errors)
   );

   // 20 ns clock
   initial begin
      pll_clk = 1'b0;
      forever #(CLK_HALF_NS) pll_clk = ~pll_clk;
   end

   // Cycles spent out of reset, used to count elapsed sample periods
   always @(posedge pll_clk) begin
      if (!rst && pll_locked) begin
         active_cycles <= active_cycles + 1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////////

   // Numerical Recipes LCG constants
   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   // Top bits of the LCG are the best mixed, use them for the switches
   task automatic update_switches();
      lcg_state = lcg_next(lcg_state);
      gain_n    = lcg_state[31];
      shdn_n    = lcg_state[30];
   endtask

   task automatic wait_frame_end();
      while (dac_csn !== 1'b0) @(negedge pll_clk);
      while (dac_csn !== 1'b1) @(negedge pll_clk);
   endtask

   // Pins in order csn, sclk, led, overrun
   task automatic check_reset_state(input string where);
      if ({dac_csn, dac_sclk, led, overrun} !== 4'b1000) begin
         tb_errors++;
         $display("Fail reset_state %s: expected %b, actual %b", where, 4'b1000,
                  {dac_csn, dac_sclk, led, overrun});
      end
   endtask

   // Let frames pass, moving the switches in the idle part of each period
   task automatic run_frames(input int count);
      for (int i = 0; i < count; i++) begin
         wait_frame_end();
         repeat (SWITCH_DELAY) @(negedge pll_clk);
         if (dac_csn !== 1'b1) begin
            tb_errors++;
            $display("Switch update window missed, chip select was low");
         end
         update_switches();
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      rst        = 1'b1;
      pll_locked = 1'b1;
      gain_n     = 1'b1;
      shdn_n     = 1'b1;
      tb_errors  = 0;
      periods    = 0;
      lcg_state  = 32'hc22b_fd95;
      repeat (3) @(negedge pll_clk);
      rst = 1'b0;
      // Reset state, first tick is still far away
      repeat (3) @(negedge pll_clk);
      check_reset_state("after reset");
      run_frames(FRAMES_PER_PHASE);
      periods = active_cycles / TICK_CYCLES;
      // PLL loses lock for 3 cycles in the middle of a frame
      while (dac_csn !== 1'b0) @(negedge pll_clk);
      repeat (LOCK_LOSS_DELAY) @(negedge pll_clk);
      pll_locked = 1'b0;
      repeat (3) @(negedge pll_clk);
      pll_locked  = 1'b1;
      cycles_mark = active_cycles;
      repeat (3) @(negedge pll_clk);
      check_reset_state("after PLL relock");
      run_frames(FRAMES_PER_PHASE);
      periods    = periods + (active_cycles - cycles_mark) / TICK_CYCLES;
      frame_diff = frame_count - periods;
      if (frame_diff > 1 || frame_diff < -1) begin
         tb_errors++;
         $display("Fail frame_rate: expected %0d frames (+/-1), actual %0d", periods, frame_count);
      end
      $display("Frames %0d, periods %0d, checker errors %0d, testbench errors %0d",
               frame_count, periods, checker_errors, tb_errors);
      if (checker_errors + tb_errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(WATCHDOG_NS);
      $display("Timeout, the run did not finish within %0d ns", WATCHDOG_NS);
      $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
src/dac_pkg.sv
src/tick_divider.sv
src/ramp_counter.sv
src/spi_tx.sv
src/dac_ctrl.sv
src/dac_sawtooth.sv
dv/dac_frame_checker.sv
dv/tb_dac_sawtooth.sv

//--- run.sh
#!/bin/sh
# Build and run the sawtooth DAC testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f verilog.f --top-module tb_dac_sawtooth \
   && ./obj_dir/Vtb_dac_sawtooth > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Simulation completed successfully" sim.log \
   && { echo "Run passed"; exit 0; } \
   || { echo "Run failed, see sim.log"; exit 1; }
